/* Bender.yml */
package:
  name: recovery_executor

sources:
  - include_dirs:
      - include
    files:
      - source/recovery_cmd_pkg.sv
      - source/recovery_reg_pkg.sv
      - source/recovery_cmd_executor.sv
      - source/recovery_reg_arbiter.sv
      - source/recovery_reg_bank.sv
      - source/recovery_apb_port.sv
      - source/recovery_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/recovery_assertions.sv
      - dv/tb_recovery_top.sv

/* dv/recovery_assertions.sv */
// Executor handshake checks, bound into every executor; checks are off while rst_ni is low
`timescale 1ns/1ns
`include "recovery_cfg.svh"

module recovery_assertions (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   cmd_done_o,
  input logic                   res_dvalid_o,
  input logic                   res_dready_i,
  input logic [7:0]             res_data_o,
  input logic                   res_dlast_o,
  input logic                   req_o,
  input logic                   gnt_i,
  input logic                   we_o,
  input logic [`REC_IDX_W-1:0]  idx_o,
  input logic [`REC_DATA_W-1:0] wdata_o
);

  // Done is a single-cycle pulse
  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_o |=> !cmd_done_o)
    else $error("cmd_done_o stayed high for more than one cycle");

  // Response byte holds under back-pressure
  byte_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_o && !res_dready_i |=>
      res_dvalid_o && $stable(res_data_o) && $stable(res_dlast_o))
    else $error("response byte changed or dropped before res_dready_i");

  // Bus request and its fields hold until granted
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o && !gnt_i |=> req_o && $stable(we_o) && $stable(idx_o) && $stable(wdata_o))
    else $error("executor bus request changed before its grant");

endmodule

bind recovery_cmd_executor recovery_assertions u_assertions (
  .clk_i, .rst_ni, .cmd_done_o, .res_dvalid_o, .res_dready_i, .res_data_o, .res_dlast_o,
  .req_o, .gnt_i, .we_o, .idx_o, .wdata_o
);

/* dv/tb_recovery_top.sv */
// Table-driven test of recovery_top; write commands carry at most one data word
`timescale 1ns/1ns
`include "recovery_cfg.svh"

module tb_recovery_top;
  import recovery_cmd_pkg::*;

  typedef enum logic [2:0] {
    APB_READ,
    APB_FILL,
    CMD_WRITE,
    CMD_READ,
    CMD_READ_APB
  } step_kind_e;

  typedef struct packed {
    step_kind_e             kind;
    logic [7:0]             op;
    logic [`REC_LEN_W-1:0]  len;
    logic                   mode;
    logic                   crc;
    logic [`REC_DATA_W-1:0] data;
    logic [`REC_LEN_W-1:0]  exp_len;
  } step_t;

  localparam int N_STEPS = 15;
  localparam int CYCLE_LIMIT = 200 * N_STEPS;

  // kind, opcode or word index, length, mode, crc, data, expected response length
  localparam step_t STEPS [N_STEPS] = '{
    '{APB_READ,     8'd7,  16'd0,  1'b0, 1'b0, 32'h0000_0000, 16'd0},
    '{APB_FILL,     8'd0,  16'd0,  1'b0, 1'b0, 32'h0000_0000, 16'd0},
    '{CMD_READ,     8'd35, 16'd24, 1'b0, 1'b0, 32'h0000_0000, 16'd24},
    '{CMD_WRITE,    8'd38, 16'd4,  1'b0, 1'b0, 32'h000F_0000, 16'd0},
    '{APB_READ,     8'd13, 16'd0,  1'b0, 1'b0, 32'h0000_0000, 16'd0},
    '{CMD_WRITE,    8'd40, 16'd4,  1'b1, 1'b0, 32'hDEAD_BEEF, 16'd0},
    '{APB_READ,     8'd15, 16'd0,  1'b0, 1'b0, 32'h0000_0000, 16'd0},
    '{CMD_READ,     8'd39, 16'd0,  1'b0, 1'b1, 32'h0000_0000, 16'd0},
    '{APB_READ,     8'd10, 16'd0,  1'b0, 1'b0, 32'h0000_0000, 16'd0},
    '{CMD_READ,     8'd34, 16'd0,  1'b0, 1'b0, 32'h0000_0000, 16'd15},
    '{APB_READ,     8'd10, 16'd0,  1'b0, 1'b0, 32'h0000_0000, 16'd0},
    '{CMD_READ,     8'd40, 16'd0,  1'b0, 1'b0, 32'h0000_0000, 16'd0},
    '{CMD_READ,     8'd45, 16'd0,  1'b1, 1'b0, 32'h0000_0000, 16'd0},
    '{CMD_READ,     8'd40, 16'd0,  1'b1, 1'b0, 32'h0000_0000, 16'd4},
    '{CMD_READ_APB, 8'd35, 16'd24, 1'b0, 1'b0, 32'h0000_00E2, 16'd24}
  };

  logic clk_i, rst_ni, recovery_mode_i;
  logic cmd_valid_i, cmd_is_rd_i, cmd_error_i, cmd_done_o;
  command_e cmd_cmd_i;
  logic [`REC_LEN_W-1:0] cmd_len_i, res_len_o;
  logic cmd_data_valid_i, cmd_data_ready_o;
  logic [`REC_DATA_W-1:0] cmd_data_i, pwdata_i, prdata_o;
  logic res_valid_o, res_ready_i, res_dvalid_o, res_dready_i, res_dlast_o;
  logic [7:0] res_data_o;
  logic psel_i, penable_i, pwrite_i, pready_o, image_activated_o;
  logic [`REC_IDX_W-1:0] paddr_i;

  // Expected bank contents
  logic [`REC_DATA_W-1:0] model [`REC_NUM_REGS];
  int cycles = 0;

  recovery_top uut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  task automatic report_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Word index of each opcode's block
  function automatic logic [3:0] block_base(input logic [7:0] op);
    case (op)
      8'd34:   return 4'd0;
      8'd35:   return 4'd4;
      8'd36:   return 4'd10;
      8'd37:   return 4'd12;
      8'd38:   return 4'd13;
      8'd39:   return 4'd14;
      default: return 4'd15;
    endcase
  endfunction

  task automatic apb_transfer(input logic wr, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    do @(negedge clk_i); while (!pready_o);
    rdata = prdata_o;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, data, unused);
    model[addr] = data;
  endtask

  task automatic apb_check(input logic [3:0] addr);
    logic [31:0] rd;
    apb_transfer(1'b0, addr, '0, rd);
    assert (rd === model[addr])
      else report_error($sformatf("APB word %0d read %h, expected %h", addr, rd, model[addr]));
  endtask

  task automatic send_word(input logic [31:0] w);
    repeat ($urandom_range(3)) @(posedge clk_i);
    @(posedge clk_i);
    cmd_data_valid_i <= 1'b1;
    cmd_data_i       <= w;
    do @(negedge clk_i); while (!cmd_data_ready_o);
    @(posedge clk_i);
    cmd_data_valid_i <= 1'b0;
  endtask

  // Header handshake, then bytes under random back-pressure
  task automatic stream_response(input logic [3:0] base, input int n);
    int got;
    logic [7:0] exp_byte;
    do @(negedge clk_i); while (!res_valid_o);
    assert (res_len_o == n)
      else report_error($sformatf("res_len_o is %0d, expected %0d", res_len_o, n));
    @(posedge clk_i);
    res_ready_i <= 1'b1;
    @(negedge clk_i);
    assert (res_valid_o) else report_error("res_valid_o dropped before res_ready_i");
    @(posedge clk_i);
    res_ready_i <= 1'b0;
    got = 0;
    while (got < n) begin
      @(posedge clk_i);
      res_dready_i <= ($urandom_range(3) != 0);
      @(negedge clk_i);
      if (res_dvalid_o && res_dready_i) begin
        exp_byte = model[base + got / 4][8 * (got % 4) +: 8];
        assert (res_data_o == exp_byte && res_dlast_o == (got == n - 1))
          else report_error($sformatf("byte %0d is %h last %b, expected %h", got,
                                      res_data_o, res_dlast_o, exp_byte));
        got++;
      end
    end
    @(posedge clk_i);
    res_dready_i <= 1'b0;
  endtask

  task automatic wait_done();
    do begin
      @(negedge clk_i);
      assert (!res_valid_o && !res_dvalid_o)
        else report_error("response seen where none was expected");
    end while (!cmd_done_o);
  endtask

  task automatic run_command(input step_t st);
    logic [3:0] base;
    base = block_base(st.op);
    @(posedge clk_i);
    recovery_mode_i <= st.mode;
    cmd_valid_i     <= 1'b1;
    cmd_is_rd_i     <= (st.kind != CMD_WRITE);
    cmd_cmd_i       <= command_e'(st.op);
    cmd_len_i       <= st.len;
    cmd_error_i     <= st.crc;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    if (st.kind == CMD_WRITE && st.len != 0) send_word(st.data);
    if (st.exp_len != 0) stream_response(base, st.exp_len);
    wait_done();
    // Executor may only write DEVICE_RESET and RECOVERY_CTRL
    if (st.kind == CMD_WRITE && (st.op == 8'd37 || st.op == 8'd38)) model[base] = st.data;
    model[10][15:8] = st.crc ? 8'h04 : 8'h00;
  endtask

  initial begin
    void'($urandom(32'h59bf_0066));
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    recovery_mode_i  = 1'b0;
    cmd_valid_i      = 1'b0;
    cmd_is_rd_i      = 1'b0;
    cmd_cmd_i        = CMD_PROT_CAP;
    cmd_len_i        = '0;
    cmd_error_i      = 1'b0;
    cmd_data_valid_i = 1'b0;
    cmd_data_i       = '0;
    res_ready_i      = 1'b0;
    res_dready_i     = 1'b0;
    psel_i           = 1'b0;
    penable_i        = 1'b0;
    pwrite_i         = 1'b0;
    paddr_i          = '0;
    pwdata_i         = '0;
    for (int i = 0; i < `REC_NUM_REGS; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!cmd_done_o && !res_valid_o && !res_dvalid_o && !cmd_data_ready_o && !pready_o)
      else report_error("outputs not idle after reset");

    for (int s = 0; s < N_STEPS; s++) begin
      case (STEPS[s].kind)
        APB_READ: apb_check(STEPS[s].op[3:0]);
        APB_FILL: begin
          for (int i = 0; i < `REC_NUM_REGS; i++) begin
            apb_write(4'(i), $urandom);
          end
          for (int i = 0; i < `REC_NUM_REGS; i++) begin
            apb_check(4'(i));
          end
        end
        CMD_READ_APB: begin
          // Software reads land in the middle of the byte stream
          fork
            run_command(STEPS[s]);
            begin
              repeat (10) @(posedge clk_i);
              apb_check(STEPS[s].data[3:0]);
              apb_check(STEPS[s].data[7:4]);
            end
          join
        end
        default: run_command(STEPS[s]);
      endcase
      @(negedge clk_i);
      assert (image_activated_o == (model[13][23:16] == 8'h0F))
        else report_error($sformatf("image_activated_o is %b after step %0d",
                                    image_activated_o, s));
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* include/recovery_cfg.svh */
// Bank geometry and command limits; REC_IDX_W must cover REC_NUM_REGS and data stays 32 bits
`ifndef RECOVERY_CFG_SVH
`define RECOVERY_CFG_SVH

// Register word and write data width
`define REC_DATA_W 32

// Byte count carried by a command
`define REC_LEN_W 16

// Local recovery register bank
`define REC_NUM_REGS 16
`define REC_IDX_W 4

// First opcode that is only legal in recovery mode
`define REC_MODE_ONLY_MIN 40

`endif

/* source/recovery_apb_port.sv */
// APB slave with word addressing and full-word writes; no error response is returned
`timescale 1ns/1ns
`include "recovery_cfg.svh"

module recovery_apb_port (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`REC_IDX_W-1:0]  paddr_i,
  input  logic [`REC_DATA_W-1:0] pwdata_i,
  output logic                   pready_o,
  output logic [`REC_DATA_W-1:0] prdata_o,
  output logic                   req_o,
  output logic                   we_o,
  output logic [`REC_IDX_W-1:0]  idx_o,
  output logic [`REC_DATA_W-1:0] wdata_o,
  output logic [3:0]             be_o,
  input  logic                   gnt_i,
  input  logic [`REC_DATA_W-1:0] rdata_i
);

  logic rd_pend_q;

  // Request in the access phase until granted
  assign req_o   = psel_i && penable_i && !rd_pend_q;
  assign we_o    = pwrite_i;
  assign idx_o   = paddr_i;
  assign wdata_o = pwdata_i;
  assign be_o    = 4'b1111;

  // Granted read, data returns next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= req_o && gnt_i && !pwrite_i;
    end
  end

  assign pready_o = (req_o && gnt_i && pwrite_i) || rd_pend_q;
  assign prdata_o = rdata_i;

endmodule

/* source/recovery_cmd_executor.sv */
// Executes one decoded command at a time; write words past the addressed block are dropped
`timescale 1ns/1ns
`include "recovery_cfg.svh"

module recovery_cmd_executor (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             recovery_mode_i,
  input  logic                             cmd_valid_i,
  input  logic                             cmd_is_rd_i,
  input  recovery_cmd_pkg::command_e       cmd_cmd_i,
  input  logic [`REC_LEN_W-1:0]            cmd_len_i,
  input  logic                             cmd_error_i,
  output logic                             cmd_done_o,
  input  logic                             cmd_data_valid_i,
  input  logic [`REC_DATA_W-1:0]           cmd_data_i,
  output logic                             cmd_data_ready_o,
  output logic                             res_valid_o,
  input  logic                             res_ready_i,
  output logic [`REC_LEN_W-1:0]            res_len_o,
  output logic                             res_dvalid_o,
  input  logic                             res_dready_i,
  output logic [7:0]                       res_data_o,
  output logic                             res_dlast_o,
  output logic                             req_o,
  output logic                             we_o,
  output recovery_reg_pkg::reg_idx_e       idx_o,
  output logic [`REC_DATA_W-1:0]           wdata_o,
  output logic [3:0]                       be_o,
  input  logic                             gnt_i,
  input  logic [`REC_DATA_W-1:0]           rdata_i
);
  import recovery_cmd_pkg::*;
  import recovery_reg_pkg::*;

  exec_state_e state_q, state_d;
  reg_idx_e idx_q, base_d;
  logic [`REC_LEN_W-1:0] blen_q, blen_d, cnt_q, wcnt_d;
  logic [2:0] blk_q;
  logic [1:0] bcnt_q;
  logic [`REC_DATA_W-1:0] word_q;
  logic held_q, pend_q, illegal, data_xfer, byte_xfer;
  protocol_error_e status_q;

  // Block base and length in bytes
  always_comb begin
    case (cmd_cmd_i)
      CMD_PROT_CAP:        begin base_d = REG_PROT_CAP_0;      blen_d = 'd15; end
      CMD_DEVICE_ID:       begin base_d = REG_DEVICE_ID_0;     blen_d = 'd24; end
      CMD_DEVICE_STATUS:   begin base_d = REG_DEVICE_STATUS_0; blen_d = 'd7;  end
      CMD_DEVICE_RESET:    begin base_d = REG_DEVICE_RESET;    blen_d = 'd3;  end
      CMD_RECOVERY_CTRL:   begin base_d = REG_RECOVERY_CTRL;   blen_d = 'd3;  end
      CMD_RECOVERY_STATUS: begin base_d = REG_RECOVERY_STATUS; blen_d = 'd2;  end
      CMD_HW_STATUS:       begin base_d = REG_HW_STATUS;       blen_d = 'd4;  end
      default:             begin base_d = REG_PROT_CAP_0;      blen_d = 'd0;  end
    endcase
  end

  assign illegal = cmd_error_i || (cmd_cmd_i < CMD_PROT_CAP) || (cmd_cmd_i > CMD_HW_STATUS) ||
                   (!recovery_mode_i && (cmd_cmd_i >= `REC_MODE_ONLY_MIN));
  // Length in whole words, rounded up
  assign wcnt_d = {2'b00, cmd_len_i[`REC_LEN_W-1:2]} + {{(`REC_LEN_W-1){1'b0}}, |cmd_len_i[1:0]};
  assign data_xfer = cmd_data_valid_i && cmd_data_ready_o;
  assign byte_xfer = res_dvalid_o && res_dready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (illegal) state_d = Error;
          else if (cmd_is_rd_i) state_d = RespLen;
          else if (wcnt_d == '0) state_d = StatusWrite;
          else state_d = RegWrite;
        end
      end
      RegWrite: begin
        if ((cnt_q == 'd1) && ((held_q && gnt_i) || (data_xfer && blk_q == '0))) begin
          state_d = StatusWrite;
        end
      end
      RespLen:     if (res_ready_i) state_d = RegRead;
      RegRead:     if (gnt_i) state_d = RespData;
      RespData: begin
        if (byte_xfer && cnt_q == 'd1) state_d = StatusWrite;
        else if (byte_xfer && bcnt_q == 2'd3) state_d = RegRead;
      end
      StatusWrite: if (gnt_i) state_d = Done;
      Error:       state_d = StatusWrite;
      default:     state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      idx_q    <= REG_PROT_CAP_0;
      blen_q   <= '0;
      cnt_q    <= '0;
      blk_q    <= '0;
      bcnt_q   <= '0;
      held_q   <= 1'b0;
      pend_q   <= 1'b0;
      status_q <= PROTOCOL_OK;
    end else begin
      state_q <= state_d;
      case (state_q)
        Idle: begin
          if (cmd_valid_i) begin
            idx_q    <= base_d;
            blen_q   <= blen_d;
            blk_q    <= 3'((blen_d + 'd3) >> 2);
            cnt_q    <= cmd_is_rd_i ? blen_d : wcnt_d;
            bcnt_q   <= '0;
            status_q <= cmd_error_i ? PROTOCOL_ERROR_CRC : PROTOCOL_OK;
          end
        end
        RegWrite: begin
          // Word outside the block is counted and dropped
          if (data_xfer && blk_q != '0) begin
            held_q <= 1'b1;
          end else if (data_xfer) begin
            cnt_q <= cnt_q - 'd1;
          end else if (held_q && gnt_i) begin
            held_q <= 1'b0;
            blk_q  <= blk_q - 3'd1;
            idx_q  <= reg_idx_e'(idx_q + 1'b1);
            cnt_q  <= cnt_q - 'd1;
          end
        end
        RegRead: if (gnt_i) pend_q <= 1'b1;
        RespData: begin
          if (pend_q) begin
            pend_q <= 1'b0;
          end else if (byte_xfer) begin
            cnt_q  <= cnt_q - 'd1;
            bcnt_q <= bcnt_q + 2'd1;
            if (bcnt_q == 2'd3) idx_q <= reg_idx_e'(idx_q + 1'b1);
          end
        end
        default: ;
      endcase
    end
  end

  // Write word from the data port, or read word from the bank
  always_ff @(posedge clk_i) begin
    if (data_xfer) word_q <= cmd_data_i;
    else if (state_q == RespData && pend_q) word_q <= rdata_i;
  end

  assign cmd_done_o       = (state_q == Done);
  assign cmd_data_ready_o = (state_q == RegWrite) && !held_q;
  assign res_valid_o      = (state_q == RespLen);
  assign res_len_o        = blen_q;
  assign res_dvalid_o     = (state_q == RespData) && !pend_q;
  assign res_data_o       = word_q[8*bcnt_q +: 8];
  assign res_dlast_o      = res_dvalid_o && (cnt_q == 'd1);

  // Bus request, status goes to byte 1 of DEVICE_STATUS_0
  assign req_o   = (state_q == RegWrite && held_q) || (state_q == RegRead) ||
                   (state_q == StatusWrite);
  assign we_o    = (state_q != RegRead);
  assign idx_o   = (state_q == StatusWrite) ? REG_DEVICE_STATUS_0 : idx_q;
  assign wdata_o = (state_q == StatusWrite) ?
                   {{(`REC_DATA_W-16){1'b0}}, status_q, 8'h00} : word_q;
  assign be_o    = (state_q == StatusWrite) ? 4'b0010 : 4'b1111;

endmodule

/* source/recovery_cmd_pkg.sv */
// Command protocol types; only opcodes 34 to 40 are defined, indirect FIFO opcodes are not
package recovery_cmd_pkg;

  // Recovery opcodes, 40 and up need recovery mode
  typedef enum logic [7:0] {
    CMD_PROT_CAP        = 8'd34,
    CMD_DEVICE_ID       = 8'd35,
    CMD_DEVICE_STATUS   = 8'd36,
    CMD_DEVICE_RESET    = 8'd37,
    CMD_RECOVERY_CTRL   = 8'd38,
    CMD_RECOVERY_STATUS = 8'd39,
    CMD_HW_STATUS       = 8'd40
  } command_e;

  // Code reported in byte 1 of DEVICE_STATUS_0
  typedef enum logic [7:0] {
    PROTOCOL_OK        = 8'h00,
    PROTOCOL_ERROR_CRC = 8'h04
  } protocol_error_e;

  // Executor FSM
  typedef enum logic [2:0] {
    Idle,
    RegWrite,
    RegRead,
    RespLen,
    RespData,
    StatusWrite,
    Done,
    Error
  } exec_state_e;

endpackage

/* source/recovery_reg_arbiter.sv */
// Fixed priority, executor first; a requester must hold its request until granted
`timescale 1ns/1ns
`include "recovery_cfg.svh"

module recovery_reg_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         exec_req_i,
  input  logic                         exec_we_i,
  input  logic [`REC_IDX_W-1:0]        exec_idx_i,
  input  logic [`REC_DATA_W-1:0]       exec_wdata_i,
  input  logic [3:0]                   exec_be_i,
  output logic                         exec_gnt_o,
  output logic [`REC_DATA_W-1:0]       exec_rdata_o,
  input  logic                         sw_req_i,
  input  logic                         sw_we_i,
  input  logic [`REC_IDX_W-1:0]        sw_idx_i,
  input  logic [`REC_DATA_W-1:0]       sw_wdata_i,
  input  logic [3:0]                   sw_be_i,
  output logic                         sw_gnt_o,
  output logic [`REC_DATA_W-1:0]       sw_rdata_o,
  output logic                         bus_req_o,
  output logic                         bus_we_o,
  output logic [`REC_IDX_W-1:0]        bus_idx_o,
  output logic [`REC_DATA_W-1:0]       bus_wdata_o,
  output logic [3:0]                   bus_be_o,
  output recovery_reg_pkg::requester_e bus_owner_o,
  input  logic [`REC_DATA_W-1:0]       bus_rdata_i
);
  import recovery_reg_pkg::*;

  requester_e rd_owner_q;

  assign exec_gnt_o  = exec_req_i;
  assign sw_gnt_o    = sw_req_i && !exec_req_i;
  assign bus_owner_o = exec_req_i ? REQ_EXEC : REQ_SW;

  assign bus_req_o   = exec_req_i || sw_req_i;
  assign bus_we_o    = exec_req_i ? exec_we_i    : sw_we_i;
  assign bus_idx_o   = exec_req_i ? exec_idx_i   : sw_idx_i;
  assign bus_wdata_o = exec_req_i ? exec_wdata_i : sw_wdata_i;
  assign bus_be_o    = exec_req_i ? exec_be_i    : sw_be_i;

  // Remember who issued the read so the data goes back to it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_owner_q <= REQ_EXEC;
    end else if (bus_req_o && !bus_we_o) begin
      rd_owner_q <= bus_owner_o;
    end
  end

  assign exec_rdata_o = (rd_owner_q == REQ_EXEC) ? bus_rdata_i : '0;
  assign sw_rdata_o   = (rd_owner_q == REQ_SW)   ? bus_rdata_i : '0;

endmodule

/* source/recovery_reg_bank.sv */
// Register bank clears to zero on reset; executor writes outside its allowed fields are dropped
`timescale 1ns/1ns
`include "recovery_cfg.svh"

module recovery_reg_bank (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         bus_req_i,
  input  logic                         bus_we_i,
  input  logic [`REC_IDX_W-1:0]        bus_idx_i,
  input  logic [`REC_DATA_W-1:0]       bus_wdata_i,
  input  logic [3:0]                   bus_be_i,
  input  recovery_reg_pkg::requester_e bus_owner_i,
  output logic [`REC_DATA_W-1:0]       bus_rdata_o,
  output logic                         image_activated_o
);
  import recovery_reg_pkg::*;

  logic [`REC_DATA_W-1:0] regs_q [`REC_NUM_REGS];
  logic [3:0] wr_be;

  // Byte enables after the write permission check
  always_comb begin
    wr_be = '0;
    if (bus_req_i && bus_we_i) begin
      if (bus_owner_i == REQ_SW) begin
        wr_be = bus_be_i;
      end else if (bus_idx_i == REG_DEVICE_RESET || bus_idx_i == REG_RECOVERY_CTRL) begin
        wr_be = bus_be_i;
      end else if (bus_idx_i == REG_DEVICE_STATUS_0) begin
        // Protocol error byte only
        wr_be = bus_be_i & 4'b0010;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `REC_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (wr_be[b]) begin
          regs_q[bus_idx_i][8*b +: 8] <= bus_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read data lands one cycle after the granted read
  always_ff @(posedge clk_i) begin
    if (bus_req_i && !bus_we_i) begin
      bus_rdata_o <= regs_q[bus_idx_i];
    end
  end

  // ACTIVATE_REC_IMG lives in byte 2 of RECOVERY_CTRL
  assign image_activated_o = (regs_q[REG_RECOVERY_CTRL][23:16] == 8'h0F);

endmodule

/* source/recovery_reg_pkg.sv */
// Register map of the 16-word recovery bank; word order follows the recovery spec blocks
`include "recovery_cfg.svh"

package recovery_reg_pkg;

  // Word index inside the bank
  typedef enum logic [`REC_IDX_W-1:0] {
    REG_PROT_CAP_0        = 4'd0,
    REG_PROT_CAP_1        = 4'd1,
    REG_PROT_CAP_2        = 4'd2,
    REG_PROT_CAP_3        = 4'd3,
    REG_DEVICE_ID_0       = 4'd4,
    REG_DEVICE_ID_1       = 4'd5,
    REG_DEVICE_ID_2       = 4'd6,
    REG_DEVICE_ID_3       = 4'd7,
    REG_DEVICE_ID_4       = 4'd8,
    REG_DEVICE_ID_5       = 4'd9,
    REG_DEVICE_STATUS_0   = 4'd10,
    REG_DEVICE_STATUS_1   = 4'd11,
    REG_DEVICE_RESET      = 4'd12,
    REG_RECOVERY_CTRL     = 4'd13,
    REG_RECOVERY_STATUS   = 4'd14,
    REG_HW_STATUS         = 4'd15
  } reg_idx_e;

  // Who owns the shared register bus
  typedef enum logic {
    REQ_EXEC = 1'b0,
    REQ_SW   = 1'b1
  } requester_e;

endpackage

/* source/recovery_top.sv */
// Recovery target top; executor and APB software share the bank, executor has bus priority
`timescale 1ns/1ns
`include "recovery_cfg.svh"

module recovery_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       recovery_mode_i,
  input  logic                       cmd_valid_i,
  input  logic                       cmd_is_rd_i,
  input  recovery_cmd_pkg::command_e cmd_cmd_i,
  input  logic [`REC_LEN_W-1:0]      cmd_len_i,
  input  logic                       cmd_error_i,
  output logic                       cmd_done_o,
  input  logic                       cmd_data_valid_i,
  input  logic [`REC_DATA_W-1:0]     cmd_data_i,
  output logic                       cmd_data_ready_o,
  output logic                       res_valid_o,
  input  logic                       res_ready_i,
  output logic [`REC_LEN_W-1:0]      res_len_o,
  output logic                       res_dvalid_o,
  input  logic                       res_dready_i,
  output logic [7:0]                 res_data_o,
  output logic                       res_dlast_o,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`REC_IDX_W-1:0]      paddr_i,
  input  logic [`REC_DATA_W-1:0]     pwdata_i,
  output logic                       pready_o,
  output logic [`REC_DATA_W-1:0]     prdata_o,
  output logic                       image_activated_o
);
  import recovery_reg_pkg::*;

  logic exec_req, exec_we, exec_gnt, sw_req, sw_we, sw_gnt, bus_req, bus_we;
  logic [`REC_IDX_W-1:0] exec_idx, sw_idx, bus_idx;
  logic [`REC_DATA_W-1:0] exec_wdata, exec_rdata, sw_wdata, sw_rdata;
  logic [`REC_DATA_W-1:0] bus_wdata, bus_rdata;
  logic [3:0] exec_be, sw_be, bus_be;
  requester_e bus_owner;

  recovery_cmd_executor u_executor (
    .clk_i, .rst_ni, .recovery_mode_i,
    .cmd_valid_i, .cmd_is_rd_i, .cmd_cmd_i, .cmd_len_i, .cmd_error_i, .cmd_done_o,
    .cmd_data_valid_i, .cmd_data_i, .cmd_data_ready_o,
    .res_valid_o, .res_ready_i, .res_len_o,
    .res_dvalid_o, .res_dready_i, .res_data_o, .res_dlast_o,
    .req_o(exec_req), .we_o(exec_we), .idx_o(exec_idx), .wdata_o(exec_wdata),
    .be_o(exec_be), .gnt_i(exec_gnt), .rdata_i(exec_rdata)
  );

  recovery_apb_port u_apb_port (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .pready_o, .prdata_o,
    .req_o(sw_req), .we_o(sw_we), .idx_o(sw_idx), .wdata_o(sw_wdata),
    .be_o(sw_be), .gnt_i(sw_gnt), .rdata_i(sw_rdata)
  );

  recovery_reg_arbiter u_arbiter (
    .clk_i, .rst_ni,
    .exec_req_i(exec_req), .exec_we_i(exec_we), .exec_idx_i(exec_idx),
    .exec_wdata_i(exec_wdata), .exec_be_i(exec_be),
    .exec_gnt_o(exec_gnt), .exec_rdata_o(exec_rdata),
    .sw_req_i(sw_req), .sw_we_i(sw_we), .sw_idx_i(sw_idx),
    .sw_wdata_i(sw_wdata), .sw_be_i(sw_be),
    .sw_gnt_o(sw_gnt), .sw_rdata_o(sw_rdata),
    .bus_req_o(bus_req), .bus_we_o(bus_we), .bus_idx_o(bus_idx),
    .bus_wdata_o(bus_wdata), .bus_be_o(bus_be), .bus_owner_o(bus_owner),
    .bus_rdata_i(bus_rdata)
  );

  recovery_reg_bank u_bank (
    .clk_i, .rst_ni,
    .bus_req_i(bus_req), .bus_we_i(bus_we), .bus_idx_i(bus_idx),
    .bus_wdata_i(bus_wdata), .bus_be_i(bus_be), .bus_owner_i(bus_owner),
    .bus_rdata_o(bus_rdata), .image_activated_o
  );

endmodule

/* verilog.f */
+incdir+include
source/recovery_cmd_pkg.sv
source/recovery_reg_pkg.sv
source/recovery_cmd_executor.sv
source/recovery_reg_arbiter.sv
source/recovery_reg_bank.sv
source/recovery_apb_port.sv
source/recovery_top.sv
dv/recovery_assertions.sv
dv/tb_recovery_top.sv
